// ==== src/issue_params.svh ====
`ifndef ISSUE_PARAMS_SVH
`define ISSUE_PARAMS_SVH

// tag width, tags run 1 .. 2**w-1.
`define ISSUE_TAG_W    4

// operand and result width.
`define ISSUE_DATA_W   32

// one station entry per tag, entry 0 unused.
`define ISSUE_RS_N     16

// dispatch queue depth.
`define ISSUE_DQ_DEPTH 4

// result queue depth.
`define ISSUE_RQ_DEPTH 4

`endif

// ==== src/issue_pkg.sv ====
`default_nettype none
`include "issue_params.svh"

package issue_pkg;

    typedef enum logic [3:0] {
        ADD  = 4'd0,
        SUB  = 4'd1,
        AND  = 4'd2,
        OR   = 4'd3,
        XOR  = 4'd4,
        SLL  = 4'd5,
        SRL  = 4'd6,
        SLT  = 4'd7,
        ADDI = 4'd8,
        XORI = 4'd9
    } alu_op_t;

    // renamed instruction from dispatch.
    typedef struct packed {
        alu_op_t                  op;
        logic [31:0]              pc;
        logic [`ISSUE_DATA_W-1:0] imm;
        logic [`ISSUE_TAG_W-1:0]  rd_tag;
        logic [`ISSUE_TAG_W-1:0]  rs1_tag;   // 0 means rs1_data is valid.
        logic [`ISSUE_DATA_W-1:0] rs1_data;
        logic [`ISSUE_TAG_W-1:0]  rs2_tag;
        logic [`ISSUE_DATA_W-1:0] rs2_data;
    } dispatch_t;

    // instruction with both operands resolved.
    typedef struct packed {
        alu_op_t                  op;
        logic [`ISSUE_DATA_W-1:0] imm;
        logic [`ISSUE_TAG_W-1:0]  rd_tag;
        logic [`ISSUE_DATA_W-1:0] rs1_data;
        logic [`ISSUE_DATA_W-1:0] rs2_data;
    } issue_t;

    // result broadcast.
    typedef struct packed {
        logic [`ISSUE_TAG_W-1:0]  tag;
        logic [`ISSUE_DATA_W-1:0] data;
    } cdb_t;

endpackage

`default_nettype wire

// ==== src/payload_fifo.sv ====
`timescale 1ns/100ps
`default_nettype none

module payload_fifo #(
    parameter type T     = logic [7:0],
    parameter int  DEPTH = 4
) (
    input  wire                           clk,
    input  wire                           rst,
    input  wire                           flush,
    input  wire                           push,
    input  wire T                         push_data,
    output logic                          full,
    input  wire                           pop,
    output T                              pop_data,
    output logic                          empty,
    output logic [$clog2(DEPTH+1)-1:0]    level
);

    localparam int PW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int LW = $clog2(DEPTH + 1);

    T              mem [DEPTH];
    logic [PW-1:0] wr_ptr;
    logic [PW-1:0] rd_ptr;
    logic [LW-1:0] count;
    logic          do_push;
    logic          do_pop;

    assign do_push  = push && !full;
    assign do_pop   = pop && !empty;
    assign full     = (count == LW'(DEPTH));
    assign empty    = (count == '0);
    assign level    = count;
    assign pop_data = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == PW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == PW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    a_no_overflow: assert property (@(posedge clk) disable iff (rst)
        !(push && full));

    a_no_underflow: assert property (@(posedge clk) disable iff (rst)
        !(pop && empty));

endmodule

`default_nettype wire

// ==== src/rs_station.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "issue_params.svh"

module rs_station import issue_pkg::*; (
    input  wire                                   clk,
    input  wire                                   rst,
    input  wire                                   flush,
    input  wire                                   wr_en,
    input  wire dispatch_t                        wr,
    input  wire                                   bc0_valid,
    input  wire cdb_t                             bc0,
    input  wire                                   bc1_valid,
    input  wire cdb_t                             bc1,
    input  wire [$clog2(`ISSUE_RQ_DEPTH+1)-1:0]   rq_level,
    output logic                                  issue_valid,
    output issue_t                                issue
);

    localparam int N  = `ISSUE_RS_N;
    localparam int TW = `ISSUE_TAG_W;
    localparam int DW = `ISSUE_DATA_W;
    localparam int LW = $clog2(`ISSUE_RQ_DEPTH + 1);

    logic [N-1:0]  occ;
    logic [N-1:0]  rdy1;
    logic [N-1:0]  rdy2;
    alu_op_t       op_q [N];
    logic [DW-1:0] imm_q [N];
    logic [TW-1:0] tag1 [N];
    logic [TW-1:0] tag2 [N];
    logic [DW-1:0] val1 [N];
    logic [DW-1:0] val2 [N];

    logic          wr_rdy1;
    logic          wr_rdy2;
    logic [DW-1:0] wr_val1;
    logic [DW-1:0] wr_val2;

    logic [N-1:0]  can_go;
    logic [TW-1:0] sel;
    logic          sel_found;
    logic [LW:0]   in_flight;
    logic          room;
    logic          do_issue;

    function automatic logic hit(input logic v, input cdb_t b, input logic [TW-1:0] t);
        return v && (b.tag == t);
    endfunction

    // operands of the incoming entry may already be on a broadcast.
    always_comb begin
        wr_rdy1 = (wr.rs1_tag == '0);
        wr_val1 = wr.rs1_data;
        if (!wr_rdy1 && hit(bc0_valid, bc0, wr.rs1_tag)) begin
            wr_rdy1 = 1'b1;
            wr_val1 = bc0.data;
        end else if (!wr_rdy1 && hit(bc1_valid, bc1, wr.rs1_tag)) begin
            wr_rdy1 = 1'b1;
            wr_val1 = bc1.data;
        end
        wr_rdy2 = (wr.rs2_tag == '0);
        wr_val2 = wr.rs2_data;
        if (!wr_rdy2 && hit(bc0_valid, bc0, wr.rs2_tag)) begin
            wr_rdy2 = 1'b1;
            wr_val2 = bc0.data;
        end else if (!wr_rdy2 && hit(bc1_valid, bc1, wr.rs2_tag)) begin
            wr_rdy2 = 1'b1;
            wr_val2 = bc1.data;
        end
    end

    assign can_go = occ & rdy1 & rdy2;

    // lowest ready index wins.
    always_comb begin
        sel       = '0;
        sel_found = 1'b0;
        for (int i = N - 1; i >= 1; i--) begin
            if (can_go[i]) begin
                sel       = TW'(i);
                sel_found = 1'b1;
            end
        end
    end

    // the ALU output and the issue register each still owe the result queue a slot.
    assign in_flight = {1'b0, rq_level} + {{LW{1'b0}}, issue_valid}
                     + {{LW{1'b0}}, bc0_valid};
    assign room      = in_flight < (LW + 1)'(`ISSUE_RQ_DEPTH);
    assign do_issue  = sel_found && room;

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            occ         <= '0;
            rdy1        <= '0;
            rdy2        <= '0;
            issue_valid <= 1'b0;
        end else begin
            for (int i = 1; i < N; i++) begin
                if (occ[i] && (hit(bc0_valid, bc0, tag1[i]) || hit(bc1_valid, bc1, tag1[i]))) begin
                    rdy1[i] <= 1'b1;
                end
                if (occ[i] && (hit(bc0_valid, bc0, tag2[i]) || hit(bc1_valid, bc1, tag2[i]))) begin
                    rdy2[i] <= 1'b1;
                end
            end
            if (wr_en) begin
                occ[wr.rd_tag]  <= 1'b1;
                rdy1[wr.rd_tag] <= wr_rdy1;
                rdy2[wr.rd_tag] <= wr_rdy2;
            end
            if (do_issue) begin
                occ[sel] <= 1'b0;   // freed as it leaves.
            end
            issue_valid <= do_issue;
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 1; i < N; i++) begin
            if (!rdy1[i] && hit(bc0_valid, bc0, tag1[i])) begin
                val1[i] <= bc0.data;
            end else if (!rdy1[i] && hit(bc1_valid, bc1, tag1[i])) begin
                val1[i] <= bc1.data;
            end
            if (!rdy2[i] && hit(bc0_valid, bc0, tag2[i])) begin
                val2[i] <= bc0.data;
            end else if (!rdy2[i] && hit(bc1_valid, bc1, tag2[i])) begin
                val2[i] <= bc1.data;
            end
        end
        if (wr_en) begin
            op_q[wr.rd_tag]  <= wr.op;
            imm_q[wr.rd_tag] <= wr.imm;
            tag1[wr.rd_tag]  <= wr.rs1_tag;
            tag2[wr.rd_tag]  <= wr.rs2_tag;
            val1[wr.rd_tag]  <= wr_val1;
            val2[wr.rd_tag]  <= wr_val2;
        end
        issue.op       <= op_q[sel];
        issue.imm      <= imm_q[sel];
        issue.rd_tag   <= sel;
        issue.rs1_data <= val1[sel];
        issue.rs2_data <= val2[sel];
    end

    a_wr_free: assert property (@(posedge clk) disable iff (rst || flush)
        wr_en |-> !occ[wr.rd_tag]);

    // an entry goes out once and is not picked again on the next cycle.
    a_issue_once: assert property (@(posedge clk) disable iff (rst || flush)
        issue_valid && do_issue |-> sel != issue.rd_tag);

endmodule

`default_nettype wire

// ==== src/alu_unit.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "issue_params.svh"

module alu_unit import issue_pkg::*; (
    input  wire         clk,
    input  wire         rst,
    input  wire         flush,
    input  wire         issue_valid,
    input  wire issue_t issue,
    output logic        alu_valid,
    output cdb_t        alu_cdb
);

    localparam int DW = `ISSUE_DATA_W;

    logic [DW-1:0] op_a;
    logic [DW-1:0] op_b;
    logic [4:0]    shamt;
    logic [DW-1:0] result;

    assign op_a  = issue.rs1_data;
    // immediate forms replace operand 2.
    assign op_b  = (issue.op == ADDI || issue.op == XORI) ? issue.imm : issue.rs2_data;
    assign shamt = op_b[4:0];

    always_comb begin
        case (issue.op)
            ADD,
            ADDI:    result = op_a + op_b;
            SUB:     result = op_a - op_b;
            AND:     result = op_a & op_b;
            OR:      result = op_a | op_b;
            XOR,
            XORI:    result = op_a ^ op_b;
            SLL:     result = op_a << shamt;
            SRL:     result = op_a >> shamt;
            SLT:     result = {{(DW-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            default: result = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            alu_valid <= 1'b0;
        end else begin
            alu_valid <= issue_valid;
        end
    end

    always_ff @(posedge clk) begin
        alu_cdb.tag  <= issue.rd_tag;
        alu_cdb.data <= result;
    end

    // results always carry a real tag.
    a_cdb_tag: assert property (@(posedge clk) disable iff (rst || flush)
        alu_valid |-> alu_cdb.tag != '0);

endmodule

`default_nettype wire

// ==== src/issue_top.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "issue_params.svh"

module issue_top import issue_pkg::*; (
    input  wire            clk,
    input  wire            rst,
    input  wire            flush,
    input  wire            disp_valid,
    output logic           disp_ready,
    input  wire dispatch_t disp,
    input  wire            ld_valid,
    input  wire cdb_t      ld,
    output logic           res_valid,
    input  wire            res_ready,
    output cdb_t           res
);

    localparam int RQ_LW = $clog2(`ISSUE_RQ_DEPTH + 1);

    logic             dq_full;
    logic             dq_empty;
    dispatch_t        dq_out;
    logic             issue_valid;
    issue_t           issue;
    logic             alu_valid;
    cdb_t             alu_cdb;
    logic             rq_empty;
    logic [RQ_LW-1:0] rq_level;

    assign disp_ready = !dq_full;
    assign res_valid  = !rq_empty;

    payload_fifo #(
        .T     (dispatch_t),
        .DEPTH (`ISSUE_DQ_DEPTH)
    ) dq_i (
        .clk       (clk),
        .rst       (rst),
        .flush     (flush),
        .push      (disp_valid && !dq_full),
        .push_data (disp),
        .full      (dq_full),
        .pop       (!dq_empty),   // station always has the slot.
        .pop_data  (dq_out),
        .empty     (dq_empty),
        .level     ()
    );

    rs_station rs_i (
        .clk         (clk),
        .rst         (rst),
        .flush       (flush),
        .wr_en       (!dq_empty),
        .wr          (dq_out),
        .bc0_valid   (alu_valid),
        .bc0         (alu_cdb),
        .bc1_valid   (ld_valid),
        .bc1         (ld),
        .rq_level    (rq_level),
        .issue_valid (issue_valid),
        .issue       (issue)
    );

    alu_unit alu_i (
        .clk         (clk),
        .rst         (rst),
        .flush       (flush),
        .issue_valid (issue_valid),
        .issue       (issue),
        .alu_valid   (alu_valid),
        .alu_cdb     (alu_cdb)
    );

    payload_fifo #(
        .T     (cdb_t),
        .DEPTH (`ISSUE_RQ_DEPTH)
    ) rq_i (
        .clk       (clk),
        .rst       (rst),
        .flush     (flush),
        .push      (alu_valid),
        .push_data (alu_cdb),
        .full      (),
        .pop       (res_valid && res_ready),
        .pop_data  (res),
        .empty     (rq_empty),
        .level     (rq_level)
    );

endmodule

`default_nettype wire

// ==== bench/issue_checker.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "issue_params.svh"

module issue_checker import issue_pkg::*; (
    input  wire            clk,
    input  wire            rst,
    input  wire            flush,
    input  wire            disp_valid,
    input  wire            disp_ready,
    input  wire dispatch_t disp,
    input  wire            ld_valid,
    input  wire cdb_t      ld,
    input  wire            res_valid,
    input  wire            res_ready,
    input  wire cdb_t      res,
    input  wire            end_check,
    output logic           all_done,
    output int             err_count,
    output int             res_count
);

    localparam int N  = `ISSUE_RS_N;
    localparam int DW = `ISSUE_DATA_W;

    logic [N-1:0]  outstanding;   // dispatched, result not yet seen.
    logic [N-1:0]  pend;          // sources still unknown.
    logic [N-1:0]  exp_known;
    logic [N-1:0]  val_known;
    dispatch_t     rec [N];
    logic [DW-1:0] exp_val [N];
    logic [DW-1:0] val [N];
    logic          cleared_q = 1'b0;

    assign all_done = (outstanding == '0);

    function automatic logic [DW-1:0] alu_model(input alu_op_t op, input logic [DW-1:0] a,
                                                input logic [DW-1:0] b,
                                                input logic [DW-1:0] imm);
        case (op)
            ADD:     return a + b;
            SUB:     return a - b;
            AND:     return a & b;
            OR:      return a | b;
            XOR:     return a ^ b;
            SLL:     return a << b[4:0];
            SRL:     return a >> b[4:0];
            SLT:     return ($signed(a) < $signed(b)) ? DW'(1) : '0;
            ADDI:    return a + imm;
            XORI:    return a ^ imm;
            default: return '0;
        endcase
    endfunction

    function automatic logic known(input logic [`ISSUE_TAG_W-1:0] t);
        return (t == '0) || val_known[t];
    endfunction

    task automatic check_result(input cdb_t r);
        res_count++;
        if (!outstanding[r.tag]) begin
            $display("error at %0t: result for tag %0d, which is not outstanding", $time, r.tag);
            err_count++;
        end else if (!exp_known[r.tag]) begin
            $display("error at %0t: result for tag %0d before its sources arrived", $time, r.tag);
            err_count++;
        end else if (r.data !== exp_val[r.tag]) begin
            $display("Mismatch at %0t: tag %0d gave %h, expected %h",
                     $time, r.tag, r.data, exp_val[r.tag]);
            err_count++;
        end
        outstanding[r.tag] = 1'b0;
    endtask

    task automatic take_dispatch(input dispatch_t d);
        if (outstanding[d.rd_tag]) begin
            $display("error at %0t: tag %0d dispatched while still outstanding", $time, d.rd_tag);
            err_count++;
        end
        // a source with no producer in flight waits for a load.
        if (d.rs1_tag != '0 && !outstanding[d.rs1_tag]) val_known[d.rs1_tag] = 1'b0;
        if (d.rs2_tag != '0 && !outstanding[d.rs2_tag]) val_known[d.rs2_tag] = 1'b0;
        rec[d.rd_tag]         = d;
        outstanding[d.rd_tag] = 1'b1;
        pend[d.rd_tag]        = 1'b1;
        exp_known[d.rd_tag]   = 1'b0;
        val_known[d.rd_tag]   = 1'b0;
    endtask

    task automatic resolve();
        logic          changed;
        logic [DW-1:0] a;
        logic [DW-1:0] b;
        changed = 1'b1;
        while (changed) begin   // chains settle in one call.
            changed = 1'b0;
            for (int t = 1; t < N; t++) begin
                if (pend[t] && known(rec[t].rs1_tag) && known(rec[t].rs2_tag)) begin
                    a = (rec[t].rs1_tag == '0) ? rec[t].rs1_data : val[rec[t].rs1_tag];
                    b = (rec[t].rs2_tag == '0) ? rec[t].rs2_data : val[rec[t].rs2_tag];
                    exp_val[t]   = alu_model(rec[t].op, a, b, rec[t].imm);
                    val[t]       = exp_val[t];
                    val_known[t] = 1'b1;
                    exp_known[t] = 1'b1;
                    pend[t]      = 1'b0;
                    changed      = 1'b1;
                end
            end
        end
    endtask

    always @(posedge clk) begin
        if (rst) begin
            err_count = 0;
            res_count = 0;
        end
        if (rst || flush) begin
            outstanding = '0;
            pend        = '0;
            exp_known   = '0;
            val_known   = '0;
        end else begin
            if (cleared_q && (!disp_ready || res_valid)) begin
                $display("error at %0t: queues not empty after reset or flush", $time);
                err_count++;
            end
            if (res_valid && res_ready) check_result(res);
            if (ld_valid) begin
                val[ld.tag]       = ld.data;
                val_known[ld.tag] = 1'b1;
            end
            if (disp_valid && disp_ready) take_dispatch(disp);
            resolve();
            if (end_check) begin
                for (int t = 1; t < N; t++) begin
                    if (outstanding[t]) begin
                        $display("error: tag %0d was dispatched but never produced a result", t);
                        err_count++;
                    end
                end
            end
        end
        cleared_q = rst || flush;
    end

endmodule

`default_nettype wire

// ==== bench/issue_tb.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "issue_params.svh"

module issue_tb import issue_pkg::*; ();

    localparam int TW = `ISSUE_TAG_W;
    localparam logic [1:0] K_IDLE  = 2'd0;
    localparam logic [1:0] K_DISP  = 2'd1;
    localparam logic [1:0] K_LOAD  = 2'd2;
    localparam logic [1:0] K_FLUSH = 2'd3;

    typedef struct packed {
        logic [1:0]    kind;
        logic          rready;
        logic          rnd;      // operand values come from the lcg.
        alu_op_t       op;
        logic [TW-1:0] rd;       // load tag on load rows.
        logic [TW-1:0] t1;
        logic [TW-1:0] t2;
        logic [31:0]   d1;       // load data on load rows.
        logic [31:0]   d2;
        logic [31:0]   imm;
    } row_t;

    logic      clk;
    logic      rst;
    logic      flush;
    logic      disp_valid;
    logic      disp_ready;
    dispatch_t disp;
    logic      ld_valid;
    cdb_t      ld;
    logic      res_valid;
    logic      res_ready;
    cdb_t      res;
    logic      end_check;
    logic      all_done;
    int        err_count;
    int        res_count;

    row_t        rows [$];
    logic [31:0] seed = 32'h2919_2077;
    int          cycles = 0;
    int          cycle_limit = 0;
    int          drain;

    issue_top issue_top_i (
        .clk        (clk),
        .rst        (rst),
        .flush      (flush),
        .disp_valid (disp_valid),
        .disp_ready (disp_ready),
        .disp       (disp),
        .ld_valid   (ld_valid),
        .ld         (ld),
        .res_valid  (res_valid),
        .res_ready  (res_ready),
        .res        (res)
    );

    issue_checker issue_checker_i (
        .clk        (clk),
        .rst        (rst),
        .flush      (flush),
        .disp_valid (disp_valid),
        .disp_ready (disp_ready),
        .disp       (disp),
        .ld_valid   (ld_valid),
        .ld         (ld),
        .res_valid  (res_valid),
        .res_ready  (res_ready),
        .res        (res),
        .end_check  (end_check),
        .all_done   (all_done),
        .err_count  (err_count),
        .res_count  (res_count)
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic add_row(input logic [1:0] kind, input logic rr, input logic rnd,
                           input alu_op_t op, input logic [TW-1:0] rd,
                           input logic [TW-1:0] t1, input logic [31:0] d1,
                           input logic [TW-1:0] t2, input logic [31:0] d2,
                           input logic [31:0] imm);
        rows.push_back('{kind: kind, rready: rr, rnd: rnd, op: op, rd: rd, t1: t1,
                         t2: t2, d1: d1, d2: d2, imm: imm});
    endtask

    task automatic dispatch_row(input logic rr, input logic rnd, input alu_op_t op,
                                input logic [TW-1:0] rd, input logic [TW-1:0] t1,
                                input logic [31:0] d1, input logic [TW-1:0] t2,
                                input logic [31:0] d2, input logic [31:0] imm);
        add_row(K_DISP, rr, rnd, op, rd, t1, d1, t2, d2, imm);
    endtask

    task automatic load_row(input logic [TW-1:0] tag, input logic [31:0] data);
        add_row(K_LOAD, 1'b1, 1'b0, ADD, tag, '0, data, '0, '0, '0);
    endtask

    task automatic idle_rows(input int n, input logic rr);
        repeat (n) add_row(K_IDLE, rr, 1'b0, ADD, '0, '0, '0, '0, '0, '0);
    endtask

    task automatic flush_row(input logic rr);
        add_row(K_FLUSH, rr, 1'b0, ADD, '0, '0, '0, '0, '0, '0);
    endtask

    task automatic build_table();
        // independent operations with every source present.
        dispatch_row(1'b1, 1'b1, ADD, 1, 0, 0, 0, 0, 0);
        dispatch_row(1'b1, 1'b1, SUB, 2, 0, 0, 0, 0, 0);
        dispatch_row(1'b1, 1'b1, AND, 3, 0, 0, 0, 0, 0);
        dispatch_row(1'b1, 1'b1, OR, 4, 0, 0, 0, 0, 0);
        dispatch_row(1'b1, 1'b1, XOR, 5, 0, 0, 0, 0, 0);
        dispatch_row(1'b1, 1'b0, SLL, 6, 0, 32'h0000_00f1, 0, 32'd35, 0);
        dispatch_row(1'b1, 1'b0, SRL, 7, 0, 32'h8000_0000, 0, 32'd4, 0);
        dispatch_row(1'b1, 1'b0, SLT, 8, 0, 32'hffff_ffff, 0, 32'd1, 0);
        dispatch_row(1'b1, 1'b0, SLT, 9, 0, 32'd1, 0, 32'hffff_ffff, 0);
        dispatch_row(1'b1, 1'b0, ADDI, 10, 0, 32'd10, 0, 32'd99, 32'hffff_ffff);
        dispatch_row(1'b1, 1'b1, XORI, 11, 0, 0, 0, 0, 32'h0f0f_0f0f);
        dispatch_row(1'b1, 1'b1, SLL, 12, 0, 0, 0, 0, 0);
        dispatch_row(1'b1, 1'b1, SRL, 13, 0, 0, 0, 0, 0);
        idle_rows(8, 1'b1);
        // dependency chain.
        dispatch_row(1'b1, 1'b0, ADDI, 1, 0, 32'd100, 0, 0, 32'd1);
        dispatch_row(1'b1, 1'b0, ADD, 2, 1, 0, 0, 32'd5, 0);
        dispatch_row(1'b1, 1'b0, SUB, 3, 2, 0, 1, 0, 0);
        dispatch_row(1'b1, 1'b0, XOR, 4, 3, 0, 2, 0, 0);
        dispatch_row(1'b1, 1'b0, SLL, 5, 4, 0, 0, 32'd2, 0);
        idle_rows(8, 1'b1);
        // operands waiting on loads with load 13 in the write cycle.
        dispatch_row(1'b1, 1'b0, ADD, 6, 12, 0, 0, 32'd1, 0);
        idle_rows(2, 1'b1);
        load_row(12, 32'h1234_5678);
        dispatch_row(1'b1, 1'b0, XOR, 7, 13, 0, 0, 32'h00ff_00ff, 0);
        load_row(13, 32'hcafe_0001);
        dispatch_row(1'b1, 1'b0, ADD, 8, 14, 0, 7, 0, 0);
        idle_rows(1, 1'b1);
        load_row(14, 32'd77);
        idle_rows(8, 1'b1);
        // result port stalled while the station keeps filling.
        idle_rows(1, 1'b0);
        for (int i = 1; i <= 8; i++) begin
            dispatch_row(1'b0, 1'b1, alu_op_t'(i % 8), TW'(i), 0, 0, 0, 0, 0);
        end
        // sources still held in the station behind the full result queue.
        dispatch_row(1'b0, 1'b0, ADD, 9, 7, 0, 8, 0, 0);
        dispatch_row(1'b0, 1'b0, SUB, 10, 9, 0, 6, 0, 0);
        idle_rows(12, 1'b0);
        idle_rows(16, 1'b1);
        // flush with work stuck in the station and the result queue.
        for (int i = 1; i <= 4; i++) begin
            dispatch_row(1'b0, 1'b1, ADD, TW'(i), 15, 0, 0, 0, 0);
        end
        dispatch_row(1'b0, 1'b1, XOR, 5, 0, 0, 0, 0, 0);
        idle_rows(3, 1'b0);
        flush_row(1'b0);
        dispatch_row(1'b1, 1'b1, SUB, 1, 0, 0, 0, 0, 0);
        dispatch_row(1'b1, 1'b1, OR, 2, 0, 0, 0, 0, 0);
        dispatch_row(1'b1, 1'b1, SLT, 3, 0, 0, 0, 0, 0);
        dispatch_row(1'b1, 1'b0, ADD, 4, 1, 0, 2, 0, 0);
        idle_rows(10, 1'b1);
    endtask

    task automatic apply_row(input row_t row, input int idx);
        logic [31:0] d1;
        logic [31:0] d2;
        d1 = row.d1;
        d2 = row.d2;
        if (row.rnd) begin
            seed = lcg_next(seed);
            d1   = seed;
            seed = lcg_next(seed);
            d2   = seed;
        end
        disp_valid = 1'b0;
        ld_valid   = 1'b0;
        flush      = 1'b0;
        res_ready  = row.rready;
        case (row.kind)
            K_DISP: begin
                while (!disp_ready) @(negedge clk);   // retry until the queue has room.
                disp_valid = 1'b1;
                disp = '{op: row.op, pc: 32'h0000_1000 + 32'(idx) * 32'd4, imm: row.imm,
                         rd_tag: row.rd, rs1_tag: row.t1, rs1_data: d1,
                         rs2_tag: row.t2, rs2_data: d2};
            end
            K_LOAD: begin
                ld_valid = 1'b1;
                ld       = '{tag: row.rd, data: d1};
            end
            K_FLUSH: flush = 1'b1;
            default: ;
        endcase
        @(negedge clk);
    endtask

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycle_limit > 0 && cycles >= cycle_limit) begin
            $display("timeout: run did not finish within %0d cycles", cycle_limit);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    initial begin
        rst        = 1'b1;
        flush      = 1'b0;
        disp_valid = 1'b0;
        disp       = '0;
        ld_valid   = 1'b0;
        ld         = '0;
        res_ready  = 1'b1;
        end_check  = 1'b0;
        build_table();
        cycle_limit = 20 * rows.size() + 100;
        repeat (3) @(negedge clk);
        rst = 1'b0;
        foreach (rows[r]) begin
            apply_row(rows[r], r);
        end
        disp_valid = 1'b0;
        ld_valid   = 1'b0;
        flush      = 1'b0;
        res_ready  = 1'b1;
        drain      = 0;
        while (!all_done && drain < 100) begin
            @(negedge clk);
            drain++;
        end
        end_check = 1'b1;   // checker lists anything still owed.
        @(negedge clk);
        end_check = 1'b0;
        @(negedge clk);
        $display("errors: %0d, results received: %0d", err_count, res_count);
        if (err_count == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== list.f ====
+incdir+src
src/issue_pkg.sv
src/payload_fifo.sv
src/rs_station.sv
src/alu_unit.sv
src/issue_top.sv
bench/issue_checker.sv
bench/issue_tb.sv

// ==== run.sh ====
#!/bin/sh
# builds the issue stage testbench with verilator and runs it.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f list.f --top-module issue_tb \
    -o issue_sim > build.log 2>&1 \
    || { cat build.log; echo "build failed"; exit 1; }

./obj_dir/issue_sim > sim.log 2>&1
cat sim.log

grep -q "TEST RESULT: FAIL" sim.log && { echo "simulation reported failure"; exit 1; }
grep -q "TEST RESULT: PASS" sim.log || { echo "no pass line found in sim.log"; exit 1; }
exit 0
